/* common/core_bus_pkg.sv */
// records passed between core blocks
`default_nettype none

package core_bus_pkg;

    import rv_isa_pkg::*;

    // decoder output
    typedef struct packed {
        opcode_t    opcode;
        logic [2:0] funct3;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        inst_kind_t inst_kind;
        alu_op_t    alu_op;
        word_t      imm;     // already sign extended
    } decoded_t;

    // one finished instruction
    typedef struct packed {
        word_t    pc;
        word_t    next_pc;
        reg_idx_t rd;
        logic     rd_we;     // low for x0 and non-writing instructions
        word_t    rd_wdata;
    } retire_t;

endpackage

`default_nettype wire

/* common/rv_isa_pkg.sv */
// rv32i encoding types
`default_nettype none

`include "rv_macros.svh"

package rv_isa_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0] reg_idx_t;

    // major opcodes kept by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_t;

    typedef enum logic [2:0] {
        KIND_R,
        KIND_I,
        KIND_B,
        KIND_U,
        KIND_J,
        KIND_NONE  // unsupported encoding
    } inst_kind_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

endpackage

`default_nettype wire

/* common/rv_macros.svh */
// core sizing and reset vector
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// data and address width
`define RV_XLEN 32

// integer register count, x0 included
`define RV_REG_COUNT 32

// first fetch address
`define RV_RESET_PC 32'h8000_0000

`endif

/* compile.f */
+incdir+common
common/rv_isa_pkg.sv
common/core_bus_pkg.sv
fetch/fetch_unit.sv
logic/decoder.sv
logic/execute_unit.sv
logic/reg_file.sv
logic/retire_unit.sv
logic/rv_core.sv
verification/rv_core_tb.sv

/* fetch/fetch_unit.sv */
// instruction fetch
`timescale 1ns/100ps
`default_nettype none

`include "rv_macros.svh"

module fetch_unit import rv_isa_pkg::*; (
    input  wire   clk,
    input  wire   reset,
    input  wire   inst_valid,
    input  word_t inst_data,
    input  wire   next_valid,
    input  word_t next_pc,
    output logic  fetch_req,
    output word_t fetch_addr,
    output word_t cur_pc,
    output word_t cur_inst,
    output logic  inst_ready
);

    word_t pc;
    logic  started;   // first request after reset done
    logic  waiting;   // request out, no instruction yet

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc         <= `RV_RESET_PC;
            started    <= 1'b0;
            waiting    <= 1'b0;
            fetch_req  <= 1'b0;
            inst_ready <= 1'b0;
        end else begin
            started    <= 1'b1;
            fetch_req  <= !started || next_valid;
            inst_ready <= waiting && inst_valid;
            if (next_valid)
                pc <= next_pc;
            if (!started || next_valid)
                waiting <= 1'b1;
            else if (inst_valid)
                waiting <= 1'b0;   // stray strobes do nothing here
        end
    end

    // instruction word held until the next capture
    always_ff @(posedge clk) begin
        if (waiting && inst_valid)
            cur_inst <= inst_data;
    end

    assign fetch_addr = pc;
    assign cur_pc     = pc;

endmodule

`default_nettype wire

/* logic/decoder.sv */
// rv32i instruction decoder
`timescale 1ns/100ps
`default_nettype none

module decoder import rv_isa_pkg::*, core_bus_pkg::*; (
    input  word_t    inst,
    output decoded_t dec
);

    logic [6:0] funct7;

    assign funct7     = inst[31:25];
    assign dec.opcode = opcode_t'(inst[6:0]);
    assign dec.funct3 = inst[14:12];
    assign dec.rd     = inst[11:7];
    assign dec.rs1    = inst[19:15];
    assign dec.rs2    = inst[24:20];

    always_comb begin
        case (inst[6:0])
            OPC_OP:               dec.inst_kind = KIND_R;
            OPC_OP_IMM, OPC_JALR: dec.inst_kind = KIND_I;
            OPC_BRANCH:           dec.inst_kind = KIND_B;
            OPC_LUI, OPC_AUIPC:   dec.inst_kind = KIND_U;
            OPC_JAL:              dec.inst_kind = KIND_J;
            default:              dec.inst_kind = KIND_NONE;
        endcase
    end

    always_comb begin
        case (dec.inst_kind)
            KIND_I: dec.imm = {{20{inst[31]}}, inst[31:20]};
            KIND_B: dec.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            KIND_U: dec.imm = {inst[31:12], 12'b0};
            KIND_J: dec.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: dec.imm = '0;
        endcase
    end

    // everything outside OP and OP_IMM adds
    always_comb begin
        dec.alu_op = ALU_ADD;
        if (inst[6:0] == OPC_OP || inst[6:0] == OPC_OP_IMM) begin
            case (dec.funct3)
                3'b000: begin
                    if (dec.inst_kind == KIND_R && funct7 == 7'b0100000)
                        dec.alu_op = ALU_SUB;
                end
                3'b001: dec.alu_op = ALU_SLL;
                3'b010: dec.alu_op = ALU_SLT;
                3'b011: dec.alu_op = ALU_SLTU;
                3'b100: dec.alu_op = ALU_XOR;
                3'b101: dec.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                3'b110: dec.alu_op = ALU_OR;
                default: dec.alu_op = ALU_AND;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/execute_unit.sv */
// alu, branch compare and jump target
`timescale 1ns/100ps
`default_nettype none

module execute_unit import rv_isa_pkg::*, core_bus_pkg::*; (
    input  decoded_t dec,
    input  word_t    pc,
    input  word_t    rs1_val,
    input  word_t    rs2_val,
    output word_t    alu_result,
    output word_t    snpc,
    output logic     jump_en,
    output word_t    jump_target
);

    word_t      alu_a;
    word_t      alu_b;
    logic [4:0] shamt;
    logic       take_branch;

    assign snpc  = pc + 32'd4;
    assign shamt = alu_b[4:0];

    // operand choice
    always_comb begin
        case (dec.inst_kind)
            KIND_R: begin
                alu_a = rs1_val;
                alu_b = rs2_val;
            end
            KIND_I: begin
                alu_a = rs1_val;   // OP_IMM and JALR
                alu_b = dec.imm;
            end
            KIND_U: begin
                alu_a = (dec.opcode == OPC_LUI) ? '0 : pc;
                alu_b = dec.imm;
            end
            KIND_B, KIND_J: begin
                alu_a = pc;
                alu_b = dec.imm;
            end
            default: begin
                alu_a = rs1_val;
                alu_b = rs2_val;
            end
        endcase
    end

    always_comb begin
        case (dec.alu_op)
            ALU_SUB:  alu_result = alu_a - alu_b;
            ALU_SLL:  alu_result = alu_a << shamt;
            ALU_SLT:  alu_result = word_t'($signed(alu_a) < $signed(alu_b));
            ALU_SLTU: alu_result = word_t'(alu_a < alu_b);
            ALU_XOR:  alu_result = alu_a ^ alu_b;
            ALU_SRL:  alu_result = alu_a >> shamt;
            ALU_SRA:  alu_result = word_t'($signed(alu_a) >>> shamt);
            ALU_OR:   alu_result = alu_a | alu_b;
            ALU_AND:  alu_result = alu_a & alu_b;
            default:  alu_result = alu_a + alu_b;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            3'b000:  take_branch = (rs1_val == rs2_val);
            3'b001:  take_branch = (rs1_val != rs2_val);
            3'b100:  take_branch = ($signed(rs1_val) < $signed(rs2_val));
            3'b101:  take_branch = ($signed(rs1_val) >= $signed(rs2_val));
            3'b110:  take_branch = (rs1_val < rs2_val);
            3'b111:  take_branch = (rs1_val >= rs2_val);
            default: take_branch = 1'b0;   // reserved funct3 falls through
        endcase
    end

    always_comb begin
        jump_en     = 1'b0;
        jump_target = alu_result;
        if (dec.inst_kind == KIND_J) begin
            jump_en = 1'b1;
        end else if (dec.inst_kind == KIND_I && dec.opcode == OPC_JALR) begin
            jump_en     = 1'b1;
            jump_target = {alu_result[31:1], 1'b0};
        end else if (dec.inst_kind == KIND_B) begin
            jump_en = take_branch;
        end
    end

endmodule

`default_nettype wire

/* logic/reg_file.sv */
// integer register file
`timescale 1ns/100ps
`default_nettype none

`include "rv_macros.svh"

module reg_file import rv_isa_pkg::*; (
    input  wire      clk,
    input  wire      reset,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    input  wire      wen,
    input  reg_idx_t waddr,
    input  word_t    wdata,
    output word_t    rdata1,
    output word_t    rdata2
);

    word_t regs [`RV_REG_COUNT];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `RV_REG_COUNT; i++)
                regs[i] <= '0;
        end else if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];  // x0 hardwired
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* logic/retire_unit.sv */
// writeback and retire record
`timescale 1ns/100ps
`default_nettype none

module retire_unit import rv_isa_pkg::*, core_bus_pkg::*; (
    input  wire      clk,
    input  wire      reset,
    input  wire      inst_ready,
    input  word_t    pc,
    input  decoded_t dec,
    input  word_t    alu_result,
    input  word_t    snpc,
    input  wire      jump_en,
    input  word_t    jump_target,
    output logic     reg_wen,
    output reg_idx_t reg_waddr,
    output word_t    reg_wdata,
    output logic     retire_valid,
    output retire_t  retire,
    output logic     next_valid,
    output word_t    next_pc
);

    logic wb_en;
    logic rd_we;

    always_comb begin
        wb_en     = 1'b0;
        reg_wdata = '0;
        case (dec.opcode)
            OPC_JAL, OPC_JALR: begin
                wb_en     = 1'b1;
                reg_wdata = snpc;   // link address
            end
            OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC: begin
                wb_en     = 1'b1;
                reg_wdata = alu_result;
            end
            default: ;  // branches and unsupported encodings
        endcase
    end

    assign rd_we     = wb_en && (dec.rd != '0);
    assign reg_wen   = inst_ready && rd_we;
    assign reg_waddr = dec.rd;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            retire_valid <= 1'b0;
        else
            retire_valid <= inst_ready;
    end

    always_ff @(posedge clk) begin
        if (inst_ready) begin
            retire.pc       <= pc;
            retire.next_pc  <= jump_en ? jump_target : snpc;
            retire.rd       <= dec.rd;
            retire.rd_we    <= rd_we;
            retire.rd_wdata <= reg_wdata;
        end
    end

    // fetch restarts from the retired next pc
    assign next_valid = retire_valid;
    assign next_pc    = retire.next_pc;

endmodule

`default_nettype wire

/* logic/rv_core.sv */
// multicycle rv32i core top
`timescale 1ns/100ps
`default_nettype none

module rv_core import rv_isa_pkg::*, core_bus_pkg::*; (
    input  wire     clk,
    input  wire     reset,
    input  wire     inst_valid,
    input  word_t   inst_data,
    output logic    fetch_req,
    output word_t   fetch_addr,
    output logic    retire_valid,
    output retire_t retire
);

    word_t    cur_pc;
    word_t    cur_inst;
    logic     inst_ready;
    decoded_t dec;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    alu_result;
    word_t    snpc;
    logic     jump_en;
    word_t    jump_target;
    logic     reg_wen;
    reg_idx_t reg_waddr;
    word_t    reg_wdata;
    logic     next_valid;
    word_t    next_pc;

    fetch_unit i_fetch_unit (
        .clk(clk), .reset(reset),
        .inst_valid(inst_valid), .inst_data(inst_data),
        .next_valid(next_valid), .next_pc(next_pc),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr),
        .cur_pc(cur_pc), .cur_inst(cur_inst), .inst_ready(inst_ready)
    );

    decoder i_decoder (.inst(cur_inst), .dec(dec));

    reg_file i_reg_file (
        .clk(clk), .reset(reset),
        .raddr1(dec.rs1), .raddr2(dec.rs2),
        .wen(reg_wen), .waddr(reg_waddr), .wdata(reg_wdata),
        .rdata1(rs1_val), .rdata2(rs2_val)
    );

    execute_unit i_execute_unit (
        .dec(dec), .pc(cur_pc), .rs1_val(rs1_val), .rs2_val(rs2_val),
        .alu_result(alu_result), .snpc(snpc),
        .jump_en(jump_en), .jump_target(jump_target)
    );

    retire_unit i_retire_unit (
        .clk(clk), .reset(reset),
        .inst_ready(inst_ready), .pc(cur_pc), .dec(dec),
        .alu_result(alu_result), .snpc(snpc),
        .jump_en(jump_en), .jump_target(jump_target),
        .reg_wen(reg_wen), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .retire_valid(retire_valid), .retire(retire),
        .next_valid(next_valid), .next_pc(next_pc)
    );

endmodule

`default_nettype wire

/* verification/rv_core_tb.sv */
// rv_core testbench with reference model
`timescale 1ns/100ps
`default_nettype none

`include "rv_macros.svh"

module rv_core_tb import rv_isa_pkg::*, core_bus_pkg::*; ();

    localparam int N_ALU      = 60;
    localparam int N_UPPER    = 20;
    localparam int N_CTRL     = 60;
    localparam int N_BAD      = 20;
    localparam int N_MIXED    = 100;
    localparam int N_TOTAL    = N_ALU + N_UPPER + N_CTRL + N_BAD + N_MIXED;
    localparam int TIMEOUT_NS = (N_TOTAL * 12 + 100) * 4;   // at most 8 cycles per instruction

    logic    clk = 1'b0;
    logic    reset = 1'b1;
    logic    inst_valid;
    word_t   inst_data;
    logic    fetch_req;
    word_t   fetch_addr;
    logic    retire_valid;
    retire_t retire;

    word_t   model_regs [`RV_REG_COUNT];
    word_t   model_pc;
    retire_t exp_q [$];
    integer  seed;
    int      cycle = 0;
    int      valid_cycle;
    int      retire_cycle;
    int      retired;
    int      errors;
    int      tests_run;
    int      tests_ok;

    rv_core i_rv_core (
        .clk(clk), .reset(reset),
        .inst_valid(inst_valid), .inst_data(inst_data),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr),
        .retire_valid(retire_valid), .retire(retire)
    );

    always #2 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // random legal encoding of one class, 4 picks a class at random
    function automatic word_t gen_inst(input int cls);
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [6:0]  op;
        logic [11:0] imm;
        logic [12:0] boff;
        logic [20:0] joff;
        int          kind;
        rd   = reg_idx_t'(rand_below(8));   // few registers so values get reused
        rs1  = reg_idx_t'(rand_below(8));
        rs2  = reg_idx_t'(rand_below(8));
        f3   = 3'(rand_below(8));
        f7   = (rand_below(2) == 1 && (f3 == 3'd0 || f3 == 3'd5)) ? 7'b0100000 : 7'b0;
        imm  = 12'($random(seed));
        boff = 13'((rand_below(64) - 32) * 4);
        joff = 21'((rand_below(256) - 128) * 4);
        kind = (cls == 4) ? rand_below(4) : cls;
        case (kind)
            0: begin
                if (rand_below(2) == 0)
                    return {f7, rs2, rs1, f3, rd, 7'b0110011};
                if (f3 == 3'd1 || f3 == 3'd5)
                    return {f7, imm[4:0], rs1, f3, rd, 7'b0010011};   // shift amount only
                return {imm, rs1, f3, rd, 7'b0010011};
            end
            1: return {imm, 8'($random(seed)), rd, (f7[5] ? 7'b0110111 : 7'b0010111)};
            2: begin
                case (rand_below(4))
                    0: return {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'b1101111};
                    1: return {12'(rand_below(64) - 32), rs1, 3'b000, rd, 7'b1100111};
                    default: begin
                        f3 = 3'(rand_below(6));
                        if (f3 > 3'd1)
                            f3 = f3 + 3'd2;   // skip reserved 2 and 3
                        return {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11],
                                7'b1100011};
                    end
                endcase
            end
            default: begin
                case (rand_below(4))
                    0: op = 7'b0000011;   // load
                    1: op = 7'b0100011;   // store
                    2: op = 7'b1110011;
                    default: op = 7'b0001111;
                endcase
                return {25'($random(seed)), op};
            end
        endcase
    endfunction

    task automatic execute_model(input word_t inst, output retire_t expected);
        logic [2:0] f3;
        reg_idx_t   rd;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      res;
        word_t      npc;
        logic       wr;
        logic       alt;
        logic       taken;
        f3    = inst[14:12];
        rd    = inst[11:7];
        a     = model_regs[inst[19:15]];
        b     = model_regs[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        alt   = inst[30] && (inst[6:0] == 7'b0110011 || f3 == 3'd5);   // sub is register form only
        wr    = 1'b1;
        res   = '0;
        npc   = model_pc + 32'd4;
        case (inst[6:0])
            7'b0110011: res = alu_ref(f3, alt, a, b);
            7'b0010011: res = alu_ref(f3, alt, a, imm_i);
            7'b0110111: res = {inst[31:12], 12'b0};
            7'b0010111: res = model_pc + {inst[31:12], 12'b0};
            7'b1101111: begin
                res = model_pc + 32'd4;
                npc = model_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            7'b1100111: begin
                res = model_pc + 32'd4;
                npc = (a + imm_i) & ~32'd1;
            end
            7'b1100011: begin
                wr = 1'b0;
                case (f3)
                    3'd0: taken = (a == b);
                    3'd1: taken = (a != b);
                    3'd4: taken = ($signed(a) < $signed(b));
                    3'd5: taken = ($signed(a) >= $signed(b));
                    3'd6: taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (taken)
                    npc = model_pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            default: wr = 1'b0;   // unsupported, plain no-op
        endcase
        expected.pc       = model_pc;
        expected.next_pc  = npc;
        expected.rd       = rd;
        expected.rd_we    = wr && rd != '0;
        expected.rd_wdata = wr ? res : '0;
        if (expected.rd_we)
            model_regs[rd] = res;
        model_pc = npc;
    endtask

    task automatic flag_error(input string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic check_retire(input retire_t got, input retire_t expected);
        if (got.pc !== expected.pc || got.next_pc !== expected.next_pc ||
            got.rd !== expected.rd || got.rd_we !== expected.rd_we ||
            got.rd_wdata !== expected.rd_wdata) begin
            errors++;
            $display("Mismatch at %0t: retire got %h %h %0d %b %h, expected %h %h %0d %b %h",
                     $time, got.pc, got.next_pc, got.rd, got.rd_we, got.rd_wdata,
                     expected.pc, expected.next_pc, expected.rd, expected.rd_we,
                     expected.rd_wdata);
        end
    endtask

    task automatic check_fetch(input word_t got, input word_t expected);
        if (got !== expected) begin
            errors++;
            $display("Mismatch at %0t: fetch_addr %h, expected %h", $time, got, expected);
        end
    endtask

    always @(negedge clk) begin
        if (reset) begin
            if (fetch_req !== 1'b0 || retire_valid !== 1'b0)
                flag_error("fetch_req or retire_valid high during reset");
        end else begin
            if (retire_valid) begin
                if (exp_q.size() == 0)
                    flag_error("retire_valid with no instruction outstanding");
                else
                    check_retire(retire, exp_q.pop_front());
                if (cycle != valid_cycle + 2)
                    flag_error("retire_valid not 2 edges after inst_valid");
                retire_cycle = cycle;
                retired++;
            end
            if (fetch_req) begin
                check_fetch(fetch_addr, model_pc);
                if (retired > 0 && cycle != retire_cycle + 1)
                    flag_error("fetch_req not 1 cycle after retire_valid");
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_fetch();
        while (!fetch_req)
            next_cycle();
    endtask

    task automatic send_inst(input word_t inst);
        int      delay;
        retire_t expected;
        delay = 1 + rand_below(5);
        repeat (delay) next_cycle();
        execute_model(inst, expected);
        exp_q.push_back(expected);
        inst_valid  = 1'b1;
        inst_data   = inst;
        valid_cycle = cycle;
        next_cycle();
        inst_valid = 1'b0;
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic run_test(input string name, input int cls, input int count);
        int errors_before;
        errors_before = errors;
        for (int i = 0; i < count; i++) begin
            wait_fetch();
            send_inst(gen_inst(cls));
        end
        while (exp_q.size() != 0)
            next_cycle();
        report_test(name, errors_before);
    endtask

    initial begin
        int errors_before;
        seed         = 32'h3d720af8;
        inst_valid   = 1'b0;
        inst_data    = '0;
        valid_cycle  = 0;
        retire_cycle = 0;
        retired      = 0;
        errors       = 0;
        tests_run    = 0;
        tests_ok     = 0;
        for (int i = 0; i < `RV_REG_COUNT; i++)
            model_regs[i] = '0;
        model_pc = `RV_RESET_PC;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        errors_before = errors;
        wait_fetch();
        check_fetch(fetch_addr, `RV_RESET_PC);
        report_test("reset", errors_before);
        run_test("alu", 0, N_ALU);
        run_test("upper immediate", 1, N_UPPER);
        run_test("branch and jump", 2, N_CTRL);
        run_test("unsupported", 3, N_BAD);
        run_test("mixed timing", 4, N_MIXED);
        $display("%0d of %0d tests ok, %0d instructions retired, %0d errors",
                 tests_ok, tests_run, retired, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Error: timeout after %0d ns, the core stopped fetching or retiring", TIMEOUT_NS);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire
